// ==== isa_pkg.sv ====
package isa_pkg;

	localparam int pc_width  = 64;
	localparam int arn_width = 5;	// architected register number
	localparam int prn_width = 6;	// 64 physical registers

	// idle commit slots point at the hardwired zero register
	localparam logic [arn_width-1:0] zero_reg = 5'd31;

	// one instruction entering the rob from dispatch
	typedef struct packed {
		logic                 valid;
		logic [pc_width-1:0]  pc;
		logic [arn_width-1:0] arn;	// destination, architected
		logic [prn_width-1:0] prn;	// destination, physical
		logic                 branch;
		logic                 predict;	// predicted taken
	} dispatch_inst_t;

	// one commit slot toward the retirement rat and fetch
	typedef struct packed {
		logic                 valid;
		logic                 thread;	// 0 is thread 1
		logic [pc_width-1:0]  pc;
		logic [arn_width-1:0] arn;
		logic [prn_width-1:0] prn;
		logic                 branch;
		logic                 taken;
		logic                 mispredict;
		logic [pc_width-1:0]  target;	// resolved branch target
	} commit_t;

endpackage

// ==== rob_pkg.sv ====
package rob_pkg;

	localparam int rob_depth     = 16;	// entries per thread
	localparam int rob_idx_width = 4;
	localparam int num_threads   = 2;

	// tag handed back at dispatch and carried by the function units
	typedef struct packed {
		logic                     thread;	// 0 is thread 1, 1 is thread 2
		logic [rob_idx_width-1:0] idx;
	} rob_tag_t;

	// one stored rob entry
	typedef struct packed {
		logic                             valid;
		logic                             executed;
		logic [isa_pkg::pc_width-1:0]     pc;
		logic [isa_pkg::arn_width-1:0]    arn;
		logic [isa_pkg::prn_width-1:0]    prn;
		logic                             branch;
		logic                             predict;
		logic                             taken;	// actual direction, from the fu
		logic [isa_pkg::pc_width-1:0]     target;
	} rob_entry_t;

	// completion report from one function unit port
	typedef struct packed {
		logic                         valid;
		rob_tag_t                     tag;
		logic                         taken;
		logic [isa_pkg::pc_width-1:0] target;
	} complete_t;

	// what the commit side did this cycle, per thread
	typedef struct packed {
		logic [num_threads-1:0][1:0] count;	// entries leaving the head, 0 to 2
		logic [num_threads-1:0]      flush;	// mispredict kills the rest of the thread
	} retire_t;

endpackage

// ==== rob_dispatch.sv ====
`timescale 1ns/1ps

module rob_dispatch (
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic                                 dispatch_thread2,
	input  isa_pkg::dispatch_inst_t [1:0]        dispatch_inst,
	input  rob_pkg::retire_t                     retire,
	output rob_pkg::rob_tag_t [1:0]              load_tag,
	output logic [1:0]                           load,
	output rob_pkg::rob_tag_t [1:0]              dispatch_tag,
	output logic [rob_pkg::num_threads-1:0]      full
);

	logic [rob_pkg::num_threads-1:0][rob_pkg::rob_idx_width-1:0] tail;
	logic [rob_pkg::num_threads-1:0][rob_pkg::rob_idx_width:0]   count;	// 0 to rob_depth
	logic [1:0]                                                  n_load;

	// need room for a full pair, and a flushing thread takes nothing
	always_comb
	begin
		for (int t = 0; t < rob_pkg::num_threads; t++)
		begin
			full[t] = (count[t] > rob_pkg::rob_depth - 2) || retire.flush[t];
		end
	end

	// tags come straight off the tail of the selected thread
	always_comb
	begin
		dispatch_tag[0].thread = dispatch_thread2;
		dispatch_tag[0].idx    = tail[dispatch_thread2];
		dispatch_tag[1].thread = dispatch_thread2;
		dispatch_tag[1].idx    = tail[dispatch_thread2] + 1'b1;	// wraps around the ring
	end

	assign load_tag = dispatch_tag;
	assign load[0]  = dispatch_inst[0].valid && !full[dispatch_thread2];
	assign load[1]  = dispatch_inst[1].valid && load[0];
	assign n_load   = {1'b0, load[0]} + {1'b0, load[1]};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			for (int t = 0; t < rob_pkg::num_threads; t++)
			begin
				if (retire.flush[t])
				begin
					// tail minus count is the old head, new head is past the retired ones
					tail[t]  <= tail[t] - count[t][rob_pkg::rob_idx_width-1:0] + retire.count[t];
					count[t] <= '0;
				end
				else if (int'(dispatch_thread2) == t)
				begin
					tail[t]  <= tail[t] + n_load;
					count[t] <= count[t] + n_load - retire.count[t];
				end
				else
				begin
					count[t] <= count[t] - retire.count[t];
				end
			end
		end
	end

	no_dispatch_to_full: assert property (@(posedge clock) disable iff (reset)
		dispatch_inst[0].valid |-> !full[dispatch_thread2])
		else $error("dispatch to a full thread");

	pair_starts_at_slot1: assert property (@(posedge clock) disable iff (reset)
		dispatch_inst[1].valid |-> dispatch_inst[0].valid)
		else $error("slot 2 dispatched without slot 1");

endmodule

// ==== rob_entry_bank.sv ====
`timescale 1ns/1ps

module rob_entry_bank (
	input  logic                                                clock,
	input  logic                                                reset,
	input  isa_pkg::dispatch_inst_t [1:0]                       dispatch_inst,
	input  logic [1:0]                                          load,
	input  rob_pkg::rob_tag_t [1:0]                             load_tag,
	input  rob_pkg::complete_t [1:0]                            complete,
	input  rob_pkg::retire_t                                    retire,
	input  logic [rob_pkg::num_threads-1:0][rob_pkg::rob_idx_width-1:0] head,
	output rob_pkg::rob_entry_t [rob_pkg::num_threads-1:0][rob_pkg::rob_depth-1:0] entries
);

	logic [rob_pkg::num_threads-1:0][rob_pkg::rob_idx_width-1:0] head_plus1;

	always_comb
	begin
		for (int t = 0; t < rob_pkg::num_threads; t++)
		begin
			head_plus1[t] = head[t] + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int t = 0; t < rob_pkg::num_threads; t++)
			begin
				for (int i = 0; i < rob_pkg::rob_depth; i++)
				begin
					entries[t][i].valid    <= 1'b0;
					entries[t][i].executed <= 1'b0;
				end
			end
		end
		else
		begin
			// retire frees entries at the head, a flush frees the whole thread
			for (int t = 0; t < rob_pkg::num_threads; t++)
			begin
				if (retire.flush[t])
				begin
					for (int i = 0; i < rob_pkg::rob_depth; i++)
					begin
						entries[t][i].valid <= 1'b0;
					end
				end
				else
				begin
					if (retire.count[t] != 2'd0)
						entries[t][head[t]].valid <= 1'b0;
					if (retire.count[t] == 2'd2)
						entries[t][head_plus1[t]].valid <= 1'b0;
				end
			end

			for (int p = 0; p < 2; p++)
			begin
				if (complete[p].valid)
				begin
					entries[complete[p].tag.thread][complete[p].tag.idx].executed <= 1'b1;
					entries[complete[p].tag.thread][complete[p].tag.idx].taken    <= complete[p].taken;
					entries[complete[p].tag.thread][complete[p].tag.idx].target   <= complete[p].target;
				end
			end

			// new entries land at tags the dispatch side just handed out
			for (int s = 0; s < 2; s++)
			begin
				if (load[s])
				begin
					entries[load_tag[s].thread][load_tag[s].idx].valid    <= 1'b1;
					entries[load_tag[s].thread][load_tag[s].idx].executed <= 1'b0;
					entries[load_tag[s].thread][load_tag[s].idx].pc       <= dispatch_inst[s].pc;
					entries[load_tag[s].thread][load_tag[s].idx].arn      <= dispatch_inst[s].arn;
					entries[load_tag[s].thread][load_tag[s].idx].prn      <= dispatch_inst[s].prn;
					entries[load_tag[s].thread][load_tag[s].idx].branch   <= dispatch_inst[s].branch;
					entries[load_tag[s].thread][load_tag[s].idx].predict  <= dispatch_inst[s].predict;
				end
			end
		end
	end

	for (genvar p = 0; p < 2; p++)
	begin : g_complete_check
		complete_hits_live: assert property (@(posedge clock) disable iff (reset)
			complete[p].valid |->
				entries[complete[p].tag.thread][complete[p].tag.idx].valid &&
				!entries[complete[p].tag.thread][complete[p].tag.idx].executed)
			else $error("completion on port %0d names a dead or finished entry", p);
	end

endmodule

// ==== rob_retire.sv ====
`timescale 1ns/1ps

module rob_retire (
	input  logic                                                clock,
	input  logic                                                reset,
	input  rob_pkg::rob_entry_t [rob_pkg::num_threads-1:0][rob_pkg::rob_depth-1:0] entries,
	output isa_pkg::commit_t [1:0]                              commit,
	output logic [rob_pkg::num_threads-1:0][rob_pkg::rob_idx_width-1:0] head,
	output rob_pkg::retire_t                                    retire
);

	rob_pkg::rob_entry_t [rob_pkg::num_threads-1:0] first;	// entry at the head
	rob_pkg::rob_entry_t [rob_pkg::num_threads-1:0] second;	// the one behind it
	logic [rob_pkg::num_threads-1:0]                first_ready;
	logic [rob_pkg::num_threads-1:0]                second_ready;

	function automatic logic is_mispredict(input rob_pkg::rob_entry_t e);
		return e.branch && (e.taken != e.predict);
	endfunction

	function automatic isa_pkg::commit_t make_commit(input rob_pkg::rob_entry_t e,
		input logic thread);
		isa_pkg::commit_t c;
		c.valid      = 1'b1;
		c.thread     = thread;
		c.pc         = e.pc;
		c.arn        = e.arn;
		c.prn        = e.prn;
		c.branch     = e.branch;
		c.taken      = e.taken;
		c.mispredict = is_mispredict(e);
		c.target     = e.target;
		return c;
	endfunction

	always_comb
	begin
		for (int t = 0; t < rob_pkg::num_threads; t++)
		begin
			first[t]        = entries[t][head[t]];
			second[t]       = entries[t][head[t] + 1'b1];
			first_ready[t]  = first[t].valid && first[t].executed;
			second_ready[t] = second[t].valid && second[t].executed;
		end
	end

	// thread 1 gets slot 1 whenever its head is done
	always_comb
	begin
		commit        = '0;
		commit[0].arn = isa_pkg::zero_reg;
		commit[1].arn = isa_pkg::zero_reg;
		retire        = '0;
		if (first_ready[0])
		begin
			commit[0]       = make_commit(first[0], 1'b0);
			retire.count[0] = 2'd1;
			if (second_ready[0] && !is_mispredict(first[0]))
			begin
				commit[1]       = make_commit(second[0], 1'b0);
				retire.count[0] = 2'd2;
			end
			else if (first_ready[1])
			begin
				commit[1]       = make_commit(first[1], 1'b1);	// fill slot 2 from thread 2
				retire.count[1] = 2'd1;
			end
		end
		else if (first_ready[1])
		begin
			commit[0]       = make_commit(first[1], 1'b1);
			retire.count[1] = 2'd1;
			if (second_ready[1] && !is_mispredict(first[1]))
			begin
				commit[1]       = make_commit(second[1], 1'b1);
				retire.count[1] = 2'd2;
			end
		end

		for (int t = 0; t < rob_pkg::num_threads; t++)
		begin
			retire.flush[t] =
				(commit[0].valid && commit[0].mispredict && int'(commit[0].thread) == t) ||
				(commit[1].valid && commit[1].mispredict && int'(commit[1].thread) == t);
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			head <= '0;
		else
		begin
			for (int t = 0; t < rob_pkg::num_threads; t++)
			begin
				head[t] <= head[t] + retire.count[t];
			end
		end
	end

	// live entries sit in one run starting at the head
	for (genvar t = 0; t < rob_pkg::num_threads; t++)
	begin : g_head_check
		empty_head_empty_thread: assert property (@(posedge clock) disable iff (reset)
			!first[t].valid |-> !second[t].valid)
			else $error("thread %0d has a live entry behind an empty head", t);
	end

endmodule

// ==== rob_top.sv ====
`timescale 1ns/1ps

module rob_top (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            dispatch_thread2,
	input  isa_pkg::dispatch_inst_t [1:0]   dispatch_inst,
	input  rob_pkg::complete_t [1:0]        complete,
	output rob_pkg::rob_tag_t [1:0]         dispatch_tag,
	output logic [rob_pkg::num_threads-1:0] full,
	output isa_pkg::commit_t [1:0]          commit
);

	rob_pkg::rob_tag_t [1:0]                                     load_tag;
	logic [1:0]                                                  load;
	rob_pkg::retire_t                                            retire;
	logic [rob_pkg::num_threads-1:0][rob_pkg::rob_idx_width-1:0] head;
	rob_pkg::rob_entry_t [rob_pkg::num_threads-1:0][rob_pkg::rob_depth-1:0] entries;

	rob_dispatch u_dispatch (
		.clock            (clock),
		.reset            (reset),
		.dispatch_thread2 (dispatch_thread2),
		.dispatch_inst    (dispatch_inst),
		.retire           (retire),
		.load_tag         (load_tag),
		.load             (load),
		.dispatch_tag     (dispatch_tag),
		.full             (full)
	);

	rob_entry_bank u_bank (
		.clock         (clock),
		.reset         (reset),
		.dispatch_inst (dispatch_inst),
		.load          (load),
		.load_tag      (load_tag),
		.complete      (complete),
		.retire        (retire),
		.head          (head),
		.entries       (entries)
	);

	rob_retire u_retire (
		.clock   (clock),
		.reset   (reset),
		.entries (entries),
		.commit  (commit),
		.head    (head),
		.retire  (retire)
	);

endmodule

// ==== rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb;

	localparam int  num_rows = 17;
	localparam time period   = 100ns;

	// one table instruction, actual outcome included
	typedef struct packed {
		logic [isa_pkg::pc_width-1:0]  pc;
		logic [isa_pkg::arn_width-1:0] arn;
		logic [isa_pkg::prn_width-1:0] prn;
		logic                          branch;
		logic                          predict;
		logic                          taken;	// what the function unit reports
		logic [isa_pkg::pc_width-1:0]  target;
	} slot_t;

	typedef struct packed {
		logic        thread;	// 0 is thread 1
		logic        pair;
		logic        drain;	// complete everything in flight and wait for the commits
		logic [1:0]  exp_full;
		slot_t [1:0] slot;
	} row_t;

	typedef struct packed {
		isa_pkg::commit_t                  c;
		logic [rob_pkg::rob_idx_width-1:0] idx;
	} expect_t;

	logic                          clock            = 1'b0;
	logic                          reset            = 1'b1;
	logic                          dispatch_thread2 = 1'b0;
	isa_pkg::dispatch_inst_t [1:0] dispatch_inst    = '0;
	rob_pkg::complete_t [1:0]      complete         = '0;
	rob_pkg::rob_tag_t [1:0]       dispatch_tag;
	logic [1:0]                    full;
	isa_pkg::commit_t [1:0]        commit;

	row_t                              tbl [num_rows];
	expect_t                           exp_q [2][$];	// reference model, oldest first
	rob_pkg::complete_t                pending [$];	// dispatched but not yet completed
	logic [rob_pkg::rob_idx_width-1:0] tail [2];
	int                                dual_commits = 0;	// cycles with both slots valid

	rob_top u_dut (.*);

	always #(period / 2) clock = ~clock;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [159:0] expected,
		input logic [159:0] actual);
		if (expected !== actual)
		begin
			abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	function automatic slot_t make_slot(input int r, input int s, input logic [2:0] bpt);
		slot_t x;
		x.pc      = 64'h4000 + 64'(r * 8 + s * 4);
		x.arn     = 5'((r * 2 + s) % 31);
		x.prn     = 6'((r * 2 + s + 7) % 64);
		x.branch  = bpt[2];
		x.predict = bpt[1];
		x.taken   = bpt[0];
		x.target  = 64'h9000 + 64'(r * 16 + s);
		return x;
	endfunction

	function automatic row_t make_row(input int r, input logic thread, input logic pair,
		input logic drain, input logic [1:0] exp_full, input logic [2:0] b0, input logic [2:0] b1);
		row_t x;
		x.thread   = thread;
		x.pair     = pair;
		x.drain    = drain;
		x.exp_full = exp_full;
		x.slot[0]  = make_slot(r, 0, b0);
		x.slot[1]  = make_slot(r, 1, b1);
		return x;
	endfunction

	function automatic isa_pkg::commit_t expected_commit(input logic thread, input slot_t s);
		isa_pkg::commit_t c;
		c.valid      = 1'b1;
		c.thread     = thread;
		c.pc         = s.pc;
		c.arn        = s.arn;
		c.prn        = s.prn;
		c.branch     = s.branch;
		c.taken      = s.taken;
		c.mispredict = s.branch && (s.taken != s.predict);
		c.target     = s.target;
		return c;
	endfunction

	// shuffle, then two completions per cycle; called and left on a falling edge
	task automatic complete_all();
		rob_pkg::complete_t tmp;
		int                 j;
		for (int i = pending.size() - 1; i > 0; i--)
		begin
			j          = int'($urandom % (i + 1));
			tmp        = pending[i];
			pending[i] = pending[j];
			pending[j] = tmp;
		end
		while (pending.size() > 0)
		begin
			complete[0] = pending.pop_front();
			if (pending.size() > 0)
				complete[1] = pending.pop_front();
			@(negedge clock);
			complete = '0;
		end
	endtask

	task automatic apply_row(input int r);
		row_t    w;
		expect_t e;
		w = tbl[r];
		while (full[w.thread])
		begin
			if (pending.size() > 0)
				complete_all();
			else
				@(negedge clock);
		end
		dispatch_thread2 = w.thread;
		for (int s = 0; s < 2; s++)
		begin
			dispatch_inst[s].valid   = (s == 0) || w.pair;
			dispatch_inst[s].pc      = w.slot[s].pc;
			dispatch_inst[s].arn     = w.slot[s].arn;
			dispatch_inst[s].prn     = w.slot[s].prn;
			dispatch_inst[s].branch  = w.slot[s].branch;
			dispatch_inst[s].predict = w.slot[s].predict;
		end
		#1;
		for (int s = 0; s <= int'(w.pair); s++)
		begin
			check($sformatf("row %0d tag %0d", r, s), {w.thread, tail[w.thread]}, dispatch_tag[s]);
			e.c   = expected_commit(w.thread, w.slot[s]);
			e.idx = tail[w.thread];
			exp_q[w.thread].push_back(e);
			pending.push_back({1'b1, w.thread, tail[w.thread], w.slot[s].taken, w.slot[s].target});
			tail[w.thread]++;
		end
		@(negedge clock);
		dispatch_inst = '0;
		if (w.drain)
		begin
			complete_all();
			while (exp_q[0].size() > 0 || exp_q[1].size() > 0)
				@(posedge clock);
			@(negedge clock);
		end
		check($sformatf("row %0d full", r), w.exp_full, full);
	endtask

	// commit outputs only move on the rising edge
	always @(negedge clock)
	begin
		expect_t e;
		if (!reset)
		begin
			if (commit[0].valid && commit[1].valid)
				dual_commits++;
			if (commit[0].valid && commit[1].valid && commit[0].thread != commit[1].thread)
				check("thread 1 in slot 1", 1'b0, commit[0].thread);
			for (int s = 0; s < 2; s++)
			begin
				if (commit[s].valid && exp_q[commit[s].thread].size() == 0)
					abort_run($sformatf("commit slot %0d shows an entry that should not commit", s));
				else if (commit[s].valid)
				begin
					e = exp_q[commit[s].thread].pop_front();
					check($sformatf("commit slot %0d", s), e.c, commit[s]);
					if (e.c.mispredict)
					begin
						tail[e.c.thread] = e.idx + 1'b1;	// younger entries are gone
						exp_q[e.c.thread].delete();
					end
				end
				else
					check($sformatf("idle slot %0d arn", s), isa_pkg::zero_reg, commit[s].arn);
			end
		end
	end

	initial
	begin
		#(num_rows * 40 * period);
		abort_run("timeout: the rows did not finish within the time limit");
	end

	initial
	begin
		void'($urandom(32'hba00_cc91));
		tail[0] = '0;
		tail[1] = '0;
		tbl[0]  = make_row(0, 1'b0, 1'b1, 1'b1, 2'b00, 3'b000, 3'b000);
		tbl[1]  = make_row(1, 1'b1, 1'b0, 1'b1, 2'b00, 3'b000, 3'b000);	// first thread 2 tag
		tbl[2]  = make_row(2, 1'b0, 1'b1, 1'b0, 2'b00, 3'b000, 3'b000);
		tbl[3]  = make_row(3, 1'b1, 1'b1, 1'b1, 2'b00, 3'b000, 3'b000);	// both heads ready
		tbl[4]  = make_row(4, 1'b1, 1'b1, 1'b0, 2'b00, 3'b000, 3'b000);
		tbl[5]  = make_row(5, 1'b0, 1'b1, 1'b1, 2'b00, 3'b101, 3'b000);	// slot 2 gets flushed
		tbl[6]  = make_row(6, 1'b1, 1'b1, 1'b1, 2'b00, 3'b111, 3'b100);
		tbl[7]  = make_row(7, 1'b1, 1'b1, 1'b1, 2'b00, 3'b000, 3'b110);
		for (int r = 8; r < 15; r++)
			tbl[r] = make_row(r, 1'b0, 1'b1, 1'b0, 2'b00, 3'b000, 3'b000);
		tbl[15] = make_row(15, 1'b0, 1'b0, 1'b0, 2'b01, 3'b000, 3'b000);	// 15 in flight
		tbl[16] = make_row(16, 1'b0, 1'b1, 1'b1, 2'b00, 3'b001, 3'b000);
		repeat (2) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		check("idle after reset", 4'b0000, {commit[0].valid, commit[1].valid, full});
		for (int r = 0; r < num_rows; r++)
			apply_row(r);
		if (dual_commits > 0)
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else
			abort_run("no cycle ever committed two instructions");
	end

endmodule

// ==== src.f ====
isa_pkg.sv
rob_pkg.sv
rob_dispatch.sv
rob_entry_bank.sv
rob_retire.sv
rob_top.sv
rob_tb.sv

// ==== Bender.yml ====
package:
  name: rob_core

sources:
  - isa_pkg.sv
  - rob_pkg.sv
  - rob_dispatch.sv
  - rob_entry_bank.sv
  - rob_retire.sv
  - rob_top.sv
  - target: simulation
    files:
      - rob_tb.sv
